//--- Makefile
# Verilator build and run for the mini core subsystem

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cpu_wrapper: files.f verilog/*.sv dv/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 -f files.f \
		--top-module tb_cpu_wrapper -o Vtb_cpu_wrapper

run: obj_dir/Vtb_cpu_wrapper
	./obj_dir/Vtb_cpu_wrapper | tee run.log
	@if grep -q "Test failures found" run.log || ! grep -q "All tests passed!" run.log; then \
		echo "simulation FAILED, see run.log"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module tb_cpu_wrapper

clean:
	rm -rf obj_dir run.log

//--- dv/cpu_wrapper_asserts.sv
// Bus strobe and result flag assertions for the mini core subsystem
// Bound into cpu_wrapper so they can watch the core to RAM handshakes

`timescale 1ns/1ns

module cpu_wrapper_asserts (
    input logic clk_i,
    input logic reset_i,
    input logic instr_req_i,
    input logic instr_gnt_i,
    input logic instr_rvalid_i,
    input logic data_req_i,
    input logic data_gnt_i,
    input logic data_rvalid_i,
    input logic exit_valid_i,
    input logic tests_passed_i,
    input logic tests_failed_i
);

    // the RAM answers exactly one cycle after it grants
    instr_resp_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_req_i && instr_gnt_i |=> instr_rvalid_i)
        else $error("instr_rvalid did not follow a granted fetch");

    data_resp_a: assert property (@(posedge clk_i) disable iff (reset_i)
        data_req_i && data_gnt_i |=> data_rvalid_i)
        else $error("data_rvalid did not follow a granted data request");

    flags_exclusive_a: assert property (@(posedge clk_i)
        !(tests_passed_i && tests_failed_i))
        else $error("tests_passed and tests_failed are high together");

    // the exit result only clears through reset
    exit_sticky_a: assert property (@(posedge clk_i)
        exit_valid_i && !reset_i |=> exit_valid_i)
        else $error("exit_valid fell without a reset");

endmodule

bind cpu_wrapper cpu_wrapper_asserts asserts_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .data_req_i     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .exit_valid_i   (exit_valid_o),
    .tests_passed_i (tests_passed_o),
    .tests_failed_i (tests_failed_o)
);

//--- dv/tb_cpu_wrapper.sv
// Testbench for the mini core subsystem
// Loads random programs through the loader port, runs them and compares the
// printed characters, exit value and result flags with an instruction model

`timescale 1ns/1ns

module tb_cpu_wrapper import cpu_pkg::*; ();

    localparam int N_PROGS        = 40;
    localparam int MAX_INSTR      = 40;
    localparam int CYC_PER_INSTR  = 5;
    localparam int SETUP_CYCLES   = 80;
    localparam int TIMEOUT_CYCLES = N_PROGS * (MAX_INSTR * CYC_PER_INSTR + SETUP_CYCLES);
    // data words sit well above the program image
    localparam int DATA_BASE      = 512;
    localparam int DATA_WORDS     = 16;

    logic            clk;
    logic            reset;
    logic            fetch_enable;
    load_req_t       load;
    logic            print_valid;
    logic [7:0]      print_char;
    logic            exit_valid;
    logic [XLEN-1:0] exit_value;
    logic            tests_passed;
    logic            tests_failed;

    integer          seed = 32'h8e1c;
    int              value_errors = 0;
    int              char_errors = 0;
    int              flag_errors = 0;
    int              other_errors = 0;
    int              cycle_count = 0;
    instr_t          prog [MAX_INSTR];
    int              prog_len;
    logic [XLEN-1:0] data_init [DATA_WORDS];
    logic [7:0]      exp_chars [$];
    logic [7:0]      got_chars [$];
    logic [XLEN-1:0] exp_exit;

    cpu_wrapper #(
        .RAM_ADDR_WIDTH (10),
        .BOOT_ADDR      (16'h0000)
    ) dut (
        .clk_i          (clk),
        .reset_i        (reset),
        .fetch_enable_i (fetch_enable),
        .load_i         (load),
        .print_valid_o  (print_valid),
        .print_char_o   (print_char),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    task automatic add_instr(input opcode_e op, input logic [1:0] rd,
                             input logic [1:0] rs, input logic [15:0] imm);
        prog[prog_len] = '{opcode: op, rd: rd, rs: rs, spare: 8'h00, imm: imm};
        prog_len++;
    endtask

    task automatic gen_program(input int p);
        int          n;
        logic [1:0]  exit_reg;
        logic [15:0] addr;
        prog_len = 0;
        n = 10 + int'(pick(21));
        while (prog_len < n) begin
            addr = 16'(DATA_BASE + int'(pick(DATA_WORDS)));
            case (pick(6))
                0: add_instr(OP_LI, 2'(pick(4)), 2'd0, 16'(pick(65536)));
                1: add_instr(OP_ADDI, 2'(pick(4)), 2'd0, 16'(pick(65536)));
                2: add_instr(OP_ADD, 2'(pick(4)), 2'(pick(4)), 16'h0);
                3: add_instr(OP_LW, 2'(pick(4)), 2'd0, addr);
                4: begin
                    add_instr(OP_SW, 2'd0, 2'(pick(4)), addr);
                    // read the word straight back when there is room
                    if (prog_len < n) begin
                        add_instr(OP_LW, 2'(pick(4)), 2'd0, addr);
                    end
                end
                // forward branches land at most on the first tail instruction
                default: add_instr(OP_BNEZ, 2'd0, 2'(pick(4)), 16'(1 + pick(n - prog_len)));
            endcase
        end
        exit_reg = 2'(pick(4));
        if (p % 4 == 3) begin
            add_instr(OP_LI, exit_reg, 2'd0, 16'h0);
        end
        repeat (4) add_instr(OP_SW, 2'd0, 2'(pick(4)), PRINT_ADDR);
        add_instr(OP_SW, 2'd0, exit_reg, EXIT_ADDR);
        add_instr(OP_HALT, 2'd0, 2'd0, 16'h0);
        for (int k = 0; k < DATA_WORDS; k++) begin
            data_init[k] = $random(seed);
        end
    endtask

    // instruction-level model that predicts the printed characters and the exit value
    task automatic run_model();
        logic [XLEN-1:0] regs [4];
        logic [XLEN-1:0] dmem [DATA_WORDS];
        logic [XLEN-1:0] imm_ext;
        instr_t          ins;
        int              pc;
        logic            halted;
        regs = '{default: '0};
        dmem = data_init;
        exp_chars.delete();
        exp_exit = '0;
        halted = 1'b0;
        pc = 0;
        while (!halted && pc < MAX_INSTR) begin
            ins = prog[pc];
            imm_ext = {{(XLEN-16){ins.imm[15]}}, ins.imm};
            pc = pc + 1;
            case (ins.opcode)
                OP_LI:   regs[ins.rd] = imm_ext;
                OP_ADDI: regs[ins.rd] = regs[ins.rd] + imm_ext;
                OP_ADD:  regs[ins.rd] = regs[ins.rd] + regs[ins.rs];
                OP_LW:   regs[ins.rd] = dmem[int'(ins.imm) - DATA_BASE];
                OP_SW: begin
                    if (ins.imm == PRINT_ADDR) begin
                        exp_chars.push_back(regs[ins.rs][7:0]);
                    end else if (ins.imm == EXIT_ADDR) begin
                        exp_exit = regs[ins.rs];
                    end else begin
                        dmem[int'(ins.imm) - DATA_BASE] = regs[ins.rs];
                    end
                end
                // the offset counts from the branch itself
                OP_BNEZ: begin
                    if (regs[ins.rs] != '0) begin
                        pc = pc - 1 + int'(ins.imm);
                    end
                end
                default: halted = 1'b1;
            endcase
        end
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            char_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic apply_reset(input int p);
        @(negedge clk);
        reset = 1'b1;
        fetch_enable = 1'b0;
        repeat (3) @(negedge clk);
        check_flag($sformatf("prog%0d reset print_valid", p), 1'b0, print_valid);
        check_flag($sformatf("prog%0d reset exit_valid", p), 1'b0, exit_valid);
        check_flag($sformatf("prog%0d reset tests_passed", p), 1'b0, tests_passed);
        check_flag($sformatf("prog%0d reset tests_failed", p), 1'b0, tests_failed);
        reset = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len + DATA_WORDS; i++) begin
            @(negedge clk);
            load.we = 1'b1;
            if (i < prog_len) begin
                load.addr = 16'(i);
                load.data = prog[i];
            end else begin
                load.addr = 16'(DATA_BASE + i - prog_len);
                load.data = data_init[i - prog_len];
            end
        end
        @(negedge clk);
        load.we = 1'b0;
    endtask

    // print pulses are collected on the rising edge, where the negedge inputs are settled
    always @(posedge clk) begin
        if (print_valid) begin
            if (!fetch_enable) begin
                other_errors++;
                $display("a print pulse appeared while fetch was disabled");
            end
            got_chars.push_back(print_char);
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a program never reached its exit", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        fetch_enable = 1'b0;
        load = '0;
        for (int p = 0; p < N_PROGS; p++) begin
            gen_program(p);
            run_model();
            apply_reset(p);
            load_program();
            got_chars.delete();
            @(negedge clk);
            fetch_enable = 1'b1;
            while (!exit_valid) @(negedge clk);
            // let the HALT retire and make sure the result stays latched
            repeat (4) @(negedge clk);
            fetch_enable = 1'b0;
            check_value($sformatf("prog%0d exit_value", p), exp_exit, exit_value);
            check_flag($sformatf("prog%0d tests_passed", p), exp_exit == '0, tests_passed);
            check_flag($sformatf("prog%0d tests_failed", p), exp_exit != '0, tests_failed);
            check_flag($sformatf("prog%0d exit_valid held", p), 1'b1, exit_valid);
            check_value($sformatf("prog%0d print count", p), XLEN'(exp_chars.size()),
                        XLEN'(got_chars.size()));
            for (int i = 0; i < exp_chars.size() && i < got_chars.size(); i++) begin
                check_char($sformatf("prog%0d char%0d", p, i), exp_chars[i], got_chars[i]);
            end
        end
        $display("errors: value %0d, char %0d, flag %0d, other %0d",
                 value_errors, char_errors, flag_errors, other_errors);
        if (value_errors + char_errors + flag_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/cpu_pkg.sv
verilog/mini_core.sv
verilog/mm_ram.sv
verilog/mm_periph.sv
verilog/cpu_wrapper.sv
dv/cpu_wrapper_asserts.sv
dv/tb_cpu_wrapper.sv

//--- verilog/cpu_pkg.sv
// Shared definitions for the mini core subsystem
// Word widths, the peripheral address map, the opcode encoding and the
// packed structs that carry bus requests between the core, RAM and periphs

package cpu_pkg;

    // data and instruction word width
    localparam int XLEN    = 32;
    // data address width, counted in words
    localparam int DADDR_W = 16;

    // memory-mapped pseudo peripherals live at the top of the address space
    localparam logic [DADDR_W-1:0] PERIPH_BASE = 16'hF000;
    localparam logic [DADDR_W-1:0] PRINT_ADDR  = 16'hF000;
    localparam logic [DADDR_W-1:0] EXIT_ADDR   = 16'hF001;

    // zero-filled memory decodes as HALT, so a runaway program stops
    typedef enum logic [3:0] {
        OP_HALT = 4'h0,
        OP_LI   = 4'h1,
        OP_ADDI = 4'h2,
        OP_ADD  = 4'h3,
        OP_LW   = 4'h4,
        OP_SW   = 4'h5,
        OP_BNEZ = 4'h6
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  rd;
        logic [1:0]  rs;
        logic [7:0]  spare;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        logic [DADDR_W-1:0] addr;
        logic               we;
        logic [XLEN-1:0]    wdata;
    } data_req_t;

    // sel is 0 for the stdout register and 1 for the exit register
    typedef struct packed {
        logic            sel;
        logic [XLEN-1:0] wdata;
    } periph_wr_t;

    typedef struct packed {
        logic               we;
        logic [DADDR_W-1:0] addr;
        logic [XLEN-1:0]    data;
    } load_req_t;

endpackage

//--- verilog/cpu_wrapper.sv
// Top level of the mini core test subsystem
// Ties the core to its RAM and the stdout/exit pseudo peripherals, and
// exposes a loader port so a program can be written before fetch starts

`timescale 1ns/1ns

module cpu_wrapper import cpu_pkg::*; #(
    parameter int                 RAM_ADDR_WIDTH = 10,
    parameter logic [DADDR_W-1:0] BOOT_ADDR      = '0
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            fetch_enable_i,
    input  load_req_t       load_i,

    output logic            print_valid_o,
    output logic [7:0]      print_char_o,
    output logic            exit_valid_o,
    output logic [XLEN-1:0] exit_value_o,
    output logic            tests_passed_o,
    output logic            tests_failed_o
);

    // core to memory
    logic               instr_req;
    logic [DADDR_W-1:0] instr_addr;
    logic               instr_gnt;
    logic               instr_rvalid;
    instr_t             instr_rdata;

    logic               data_req;
    data_req_t          data_req_bits;
    logic               data_gnt;
    logic               data_rvalid;
    logic [XLEN-1:0]    data_rdata;

    // memory to peripherals
    logic               periph_wr_valid;
    periph_wr_t         periph_wr;

    mini_core #(
        .BOOT_ADDR       (BOOT_ADDR)
    ) core_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .fetch_enable_i  (fetch_enable_i),
        .instr_req_o     (instr_req),
        .instr_addr_o    (instr_addr),
        .instr_gnt_i     (instr_gnt),
        .instr_rvalid_i  (instr_rvalid),
        .instr_rdata_i   (instr_rdata),
        .data_req_o      (data_req),
        .data_req_bits_o (data_req_bits),
        .data_gnt_i      (data_gnt),
        .data_rvalid_i   (data_rvalid),
        .data_rdata_i    (data_rdata)
    );

    mm_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH)
    ) ram_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .instr_req_i       (instr_req),
        .instr_addr_i      (instr_addr),
        .instr_gnt_o       (instr_gnt),
        .instr_rvalid_o    (instr_rvalid),
        .instr_rdata_o     (instr_rdata),
        .data_req_i        (data_req),
        .data_req_bits_i   (data_req_bits),
        .data_gnt_o        (data_gnt),
        .data_rvalid_o     (data_rvalid),
        .data_rdata_o      (data_rdata),
        .load_i            (load_i),
        .periph_wr_valid_o (periph_wr_valid),
        .periph_wr_o       (periph_wr)
    );

    mm_periph periph_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .periph_wr_valid_i (periph_wr_valid),
        .periph_wr_i       (periph_wr),
        .print_valid_o     (print_valid_o),
        .print_char_o      (print_char_o),
        .exit_valid_o      (exit_valid_o),
        .exit_value_o      (exit_value_o),
        .tests_passed_o    (tests_passed_o),
        .tests_failed_o    (tests_failed_o)
    );

endmodule

//--- verilog/mini_core.sv
// Small load/store processor with four general registers
// A multi-cycle FSM fetches one word, waits for the response, executes it
// and for LW/SW issues a single data access before fetching again

`timescale 1ns/1ns

module mini_core import cpu_pkg::*; #(
    parameter logic [DADDR_W-1:0] BOOT_ADDR = '0
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               fetch_enable_i,

    output logic               instr_req_o,
    output logic [DADDR_W-1:0] instr_addr_o,
    input  logic               instr_gnt_i,
    input  logic               instr_rvalid_i,
    input  instr_t             instr_rdata_i,

    output logic               data_req_o,
    output data_req_t          data_req_bits_o,
    input  logic               data_gnt_i,
    input  logic               data_rvalid_i,
    input  logic [XLEN-1:0]    data_rdata_i
);

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT,
        ST_EXEC,
        ST_DREQ,
        ST_DWAIT,
        ST_HALT
    } state_e;

    state_e             state;
    logic [DADDR_W-1:0] pc;
    instr_t             ir;
    logic [XLEN-1:0]    regs [4];

    logic [XLEN-1:0]    rd_val;
    logic [XLEN-1:0]    rs_val;
    logic [XLEN-1:0]    imm_sext;
    logic [DADDR_W-1:0] imm_addr;

    // operand read and immediate formatting for the instruction in ir
    assign rd_val   = regs[ir.rd];
    assign rs_val   = regs[ir.rs];
    assign imm_sext = {{(XLEN-16){ir.imm[15]}}, ir.imm};
    assign imm_addr = DADDR_W'(ir.imm);

    // fetch is held off while the enable is low
    assign instr_req_o  = (state == ST_FETCH) && fetch_enable_i;
    assign instr_addr_o = pc;

    // LW and SW both take their address from the immediate
    assign data_req_o            = (state == ST_DREQ);
    assign data_req_bits_o.addr  = imm_addr;
    assign data_req_bits_o.we    = (ir.opcode == OP_SW);
    assign data_req_bits_o.wdata = rs_val;

    // the fetched word is captured once the response arrives
    always_ff @(posedge clk_i) begin
        if (state == ST_WAIT && instr_rvalid_i) begin
            ir <= instr_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ST_FETCH;
            pc    <= BOOT_ADDR;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                ST_FETCH: begin
                    if (instr_req_o && instr_gnt_i) begin
                        state <= ST_WAIT;
                    end
                end

                ST_WAIT: begin
                    if (instr_rvalid_i) begin
                        state <= ST_EXEC;
                    end
                end

                ST_EXEC: begin
                    state <= ST_FETCH;
                    pc    <= pc + 1'b1;
                    case (ir.opcode)
                        OP_LI: begin
                            regs[ir.rd] <= imm_sext;
                        end
                        OP_ADDI: begin
                            regs[ir.rd] <= rd_val + imm_sext;
                        end
                        OP_ADD: begin
                            regs[ir.rd] <= rd_val + rs_val;
                        end
                        OP_LW, OP_SW: begin
                            state <= ST_DREQ;
                        end
                        OP_BNEZ: begin
                            // taken branches are relative to the branch itself
                            if (rs_val != '0) begin
                                pc <= pc + imm_addr;
                            end
                        end
                        default: begin
                            // HALT and every unknown code park the core
                            state <= ST_HALT;
                            pc    <= pc;
                        end
                    endcase
                end

                ST_DREQ: begin
                    if (data_gnt_i) begin
                        state <= ST_DWAIT;
                    end
                end

                ST_DWAIT: begin
                    if (data_rvalid_i) begin
                        if (ir.opcode == OP_LW) begin
                            regs[ir.rd] <= data_rdata_i;
                        end
                        state <= ST_FETCH;
                    end
                end

                ST_HALT: begin
                    // only a reset restarts the core
                    state <= ST_HALT;
                end

                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

endmodule

//--- verilog/mm_periph.sv
// Pseudo peripherals for the test subsystem
// The stdout register pulses a character out for one cycle, the exit
// register latches the first exit value and raises the pass or fail flag

`timescale 1ns/1ns

module mm_periph import cpu_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,

    input  logic            periph_wr_valid_i,
    input  periph_wr_t      periph_wr_i,

    output logic            print_valid_o,
    output logic [7:0]      print_char_o,
    output logic            exit_valid_o,
    output logic [XLEN-1:0] exit_value_o,
    output logic            tests_passed_o,
    output logic            tests_failed_o
);

    logic print_wr;
    logic exit_wr;

    assign print_wr = periph_wr_valid_i && !periph_wr_i.sel;
    // later exit writes are ignored once a result has been recorded
    assign exit_wr  = periph_wr_valid_i && periph_wr_i.sel && !exit_valid_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            print_valid_o <= 1'b0;
        end else begin
            print_valid_o <= print_wr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (print_wr) begin
            print_char_o <= periph_wr_i.wdata[7:0];
        end
    end

    // the exit state is sticky until the next reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else if (exit_wr) begin
            exit_valid_o   <= 1'b1;
            exit_value_o   <= periph_wr_i.wdata;
            tests_passed_o <= (periph_wr_i.wdata == '0);
            tests_failed_o <= (periph_wr_i.wdata != '0);
        end
    end

endmodule

//--- verilog/mm_ram.sv
// Program and data RAM with memory-mapped peripheral decode
// Instruction and data ports are granted in the request cycle and answer one
// cycle later. Writes into the peripheral window are forwarded to mm_periph
// and a separate loader port writes the array directly

`timescale 1ns/1ns

module mm_ram import cpu_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic               clk_i,
    input  logic               reset_i,

    input  logic               instr_req_i,
    input  logic [DADDR_W-1:0] instr_addr_i,
    output logic               instr_gnt_o,
    output logic               instr_rvalid_o,
    output instr_t             instr_rdata_o,

    input  logic               data_req_i,
    input  data_req_t          data_req_bits_i,
    output logic               data_gnt_o,
    output logic               data_rvalid_o,
    output logic [XLEN-1:0]    data_rdata_o,

    input  load_req_t          load_i,

    output logic               periph_wr_valid_o,
    output periph_wr_t         periph_wr_o
);

    logic [XLEN-1:0]           mem [2**RAM_ADDR_WIDTH];

    logic [RAM_ADDR_WIDTH-1:0] instr_idx;
    logic [RAM_ADDR_WIDTH-1:0] data_idx;
    logic [RAM_ADDR_WIDTH-1:0] load_idx;
    logic                      in_window;
    logic                      known_periph;

    // addresses wrap modulo the RAM depth
    assign instr_idx = instr_addr_i[RAM_ADDR_WIDTH-1:0];
    assign data_idx  = data_req_bits_i.addr[RAM_ADDR_WIDTH-1:0];
    assign load_idx  = load_i.addr[RAM_ADDR_WIDTH-1:0];

    assign in_window    = (data_req_bits_i.addr >= PERIPH_BASE);
    assign known_periph = (data_req_bits_i.addr == PRINT_ADDR) ||
                          (data_req_bits_i.addr == EXIT_ADDR);

    // there is no back-pressure and every request is accepted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    // stray writes into the window simply go nowhere
    assign periph_wr_valid_o = data_req_i && data_req_bits_i.we && known_periph;
    assign periph_wr_o.sel   = (data_req_bits_i.addr == EXIT_ADDR);
    assign periph_wr_o.wdata = data_req_bits_i.wdata;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        instr_rdata_o <= instr_t'(mem[instr_idx]);
        data_rdata_o  <= in_window ? '0 : mem[data_idx];
        if (data_req_i && data_req_bits_i.we && !in_window) begin
            mem[data_idx] <= data_req_bits_i.wdata;
        end
        // the loader runs while the core is idle, so it never races a store
        if (load_i.we) begin
            mem[load_idx] <= load_i.data;
        end
    end

endmodule
